// File: all.f
+incdir+.
ddr_pkg.sv
ddr_user_if.sv
ddr_cmd_fifo.sv
ddr_mem_model.sv
ddr_test_harness.sv
ddr_test_top.sv
ddr_test_asserts.sv
tb_ddr_test_top.sv

// File: ddr_cmd_fifo.sv
`include "ddr_consts.svh"

module ddr_cmd_fifo #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,   // Head entry, valid while not empty
  output logic             empty_o,
  output logic             afull_o
);

  localparam int DEPTH = `DDR_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full  = (count == (PTR_W+1)'(DEPTH));
  assign wr_en = push_i && !full;    // Overflow drops the entry
  assign rd_en = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= data_i;
  end

  assign data_o  = mem[rd_ptr];
  assign empty_o = (count == '0);
  // Rises with margin left for a push already under way
  assign afull_o = (count >= (PTR_W+1)'(DEPTH - `DDR_AFULL_MARGIN));

endmodule

// File: ddr_consts.svh
`ifndef DDR_CONSTS_SVH
`define DDR_CONSTS_SVH

// Half-beat width; a full data beat carries two of these
`define DDR_DATA_WIDTH 64

// Burst addresses covered by one test pass
`define DDR_MEM_WORDS 32

`define DDR_ADDR_WIDTH 31   // Byte address on the user bus

// Command and data queues
`define DDR_FIFO_DEPTH 8
`define DDR_AFULL_MARGIN 2  // Free entries left when almost-full rises

`define DDR_RD_LATENCY 4    // Pop of a read to its first beat
`define DDR_CAL_CYCLES 40   // Reset release to phy-ready

`endif

// File: ddr_mem_model.sv
`include "ddr_consts.svh"

// Behavioral stand-in for the DDR2 controller and its memory
module ddr_mem_model
  import ddr_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        fault_inject_i,  // Forces read bit 0 high
  ddr_user_if.ctrl    ddr
);

  localparam int AW     = `DDR_ADDR_WIDTH;
  localparam int BA_W   = $clog2(`DDR_MEM_WORDS);
  localparam int BEAT_W = 2*`DDR_DATA_WIDTH;
  localparam int MASK_W = BEAT_W/8;
  localparam int CAL_W  = $clog2(`DDR_CAL_CYCLES + 1);
  localparam int LAT_W  = $clog2(`DDR_RD_LATENCY) + 1;

  typedef enum logic [2:0] {
    M_IDLE,
    M_WR_0,
    M_WR_1,
    M_RD_WAIT,
    M_RD_0,
    M_RD_1
  } model_state_e;

  model_state_e        mstate;
  logic [CAL_W-1:0]    cal_cnt;
  logic [LAT_W-1:0]    lat_cnt;
  logic [BA_W-1:0]     burst_addr;
  logic [BEAT_W-1:0]   mem [2*`DDR_MEM_WORDS];

  logic [AW:0]         af_dout;      // {cmd, addr}
  logic                af_empty;
  logic                af_pop;
  ddr_cmd_e            af_cmd;
  logic [MASK_W+BEAT_W-1:0] df_dout; // {mask, data}
  logic                df_empty;
  logic                df_pop;
  logic [BA_W:0]       word_idx;
  logic [BEAT_W-1:0]   wr_bits;
  logic [BEAT_W-1:0]   wr_word;
  logic [BEAT_W-1:0]   rd_word;

  ddr_cmd_fifo #(.WIDTH(AW + 1)) u_addr_fifo (
    .clk     (clk),
    .reset   (reset),
    .push_i  (ddr.af_we),
    .data_i  ({ddr.cmd, ddr.addr}),
    .pop_i   (af_pop),
    .data_o  (af_dout),
    .empty_o (af_empty),
    .afull_o (ddr.af_afull)
  );

  ddr_cmd_fifo #(.WIDTH(MASK_W + BEAT_W)) u_data_fifo (
    .clk     (clk),
    .reset   (reset),
    .push_i  (ddr.df_we),
    .data_i  ({ddr.mask, ddr.wdata}),
    .pop_i   (df_pop),
    .data_o  (df_dout),
    .empty_o (df_empty),
    .afull_o (ddr.df_afull)
  );

  assign af_cmd = ddr_cmd_e'(af_dout[AW]);
  assign af_pop = (mstate == M_IDLE) && !af_empty;  // Next command only once idle
  assign df_pop = ((mstate == M_WR_0) || (mstate == M_WR_1)) && !df_empty;

  // Burst a covers words 2a and 2a+1
  assign word_idx = {burst_addr, (mstate == M_WR_1) || (mstate == M_RD_1)};

  // Byte-mask merge for writes
  always_comb begin
    for (int i = 0; i < MASK_W; i++) begin
      wr_bits[i*8 +: 8] = {8{df_dout[BEAT_W + i]}};
    end
  end
  assign wr_word = (mem[word_idx] & ~wr_bits) | (df_dout[BEAT_W-1:0] & wr_bits);

  always_ff @(posedge clk) begin
    if (df_pop) mem[word_idx] <= wr_word;
    if (af_pop) burst_addr <= af_dout[BA_W+1:2];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mstate  <= M_IDLE;
      cal_cnt <= '0;
      lat_cnt <= '0;
    end else begin
      if (cal_cnt != CAL_W'(`DDR_CAL_CYCLES)) cal_cnt <= cal_cnt + 1'b1;
      case (mstate)
        M_IDLE: begin
          if (af_pop) begin
            lat_cnt <= '0;
            mstate  <= (af_cmd == CMD_READ) ? M_RD_WAIT : M_WR_0;
          end
        end
        M_WR_0: if (df_pop) mstate <= M_WR_1;
        M_WR_1: if (df_pop) mstate <= M_IDLE;
        M_RD_WAIT: begin
          // Pop cycle plus this wait gives the read latency
          if (lat_cnt == LAT_W'(`DDR_RD_LATENCY - 2)) mstate <= M_RD_0;
          else lat_cnt <= lat_cnt + 1'b1;
        end
        M_RD_0:  mstate <= M_RD_1;
        M_RD_1:  mstate <= M_IDLE;
        default: mstate <= M_IDLE;
      endcase
    end
  end

  assign rd_word     = mem[word_idx];
  assign ddr.rdata   = {rd_word[BEAT_W-1:1], rd_word[0] | fault_inject_i};
  assign ddr.dvalid  = (mstate == M_RD_0) || (mstate == M_RD_1);
  assign ddr.phy_rdy = (cal_cnt == CAL_W'(`DDR_CAL_CYCLES));

endmodule

// File: ddr_pkg.sv
package ddr_pkg;

  // Harness sequencer
  typedef enum logic [2:0] {
    TEST_IDLE,
    WR_BEAT_0,      // Command plus first beat
    WR_BEAT_1,      // Second beat
    TEST_WAIT,
    RD_ISSUE,
    WAIT_FOR_DATA
  } harness_state_e;

  // Same polarity as the controller's read/not-write bit
  typedef enum logic {
    CMD_WRITE = 1'b0,
    CMD_READ  = 1'b1
  } ddr_cmd_e;

  typedef struct packed {
    logic [27:0] reserved;  // Always zero
    logic        busy;
    logic        phy_rdy;
    logic        fault;
    logic        done;
  } harness_status_t;

endpackage

// File: ddr_test_asserts.sv
// Strobe, queue and burst rules seen from the controller side of the bus
module ddr_test_asserts (
  input logic clk,
  input logic reset,
  input logic af_we_i,
  input logic af_afull_i,
  input logic af_full_i,    // Address FIFO at full depth
  input logic df_we_i,
  input logic df_afull_i,
  input logic df_full_i,    // Data FIFO at full depth
  input logic dvalid_i      // Read beats, expected in pairs
);

  no_af_we_afull: assert property (
    @(posedge clk) disable iff (reset) !(af_we_i && af_afull_i)
  ) else $error("address strobe issued while the address FIFO was almost full");

  no_df_we_afull: assert property (
    @(posedge clk) disable iff (reset) !(df_we_i && df_afull_i)
  ) else $error("data strobe issued while the data FIFO was almost full");

  no_af_push_full: assert property (
    @(posedge clk) disable iff (reset) !(af_we_i && af_full_i)
  ) else $error("push into the full address FIFO");

  no_df_push_full: assert property (
    @(posedge clk) disable iff (reset) !(df_we_i && df_full_i)
  ) else $error("push into the full data FIFO");

  // Two beats and then a gap
  dvalid_paired: assert property (
    @(posedge clk) disable iff (reset) $rose(dvalid_i) |=> dvalid_i ##1 !dvalid_i
  ) else $error("read data valid was not exactly two beats long");

endmodule

bind ddr_mem_model ddr_test_asserts u_asserts (
  .clk        (clk),
  .reset      (reset),
  .af_we_i    (ddr.af_we),
  .af_afull_i (ddr.af_afull),
  .af_full_i  (u_addr_fifo.full),
  .df_we_i    (ddr.df_we),
  .df_afull_i (ddr.df_afull),
  .df_full_i  (u_data_fifo.full),
  .dvalid_i   (ddr.dvalid)
);

// File: ddr_test_harness.sv
`include "ddr_consts.svh"

module ddr_test_harness
  import ddr_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic [31:0]        harness_control_i,  // Bit 0 is start
  output harness_status_t    harness_status_o,
  ddr_user_if.harness        ddr
);

  localparam int DW     = `DDR_DATA_WIDTH;
  localparam int AW     = `DDR_ADDR_WIDTH;
  localparam int BA_W   = $clog2(`DDR_MEM_WORDS);
  localparam int MASK_W = 2*DW/8;

  harness_state_e    state;
  logic [BA_W-1:0]   addr_cnt;   // Burst address counter
  logic [DW-1:0]     data_cnt;   // Pattern counter, one step per beat
  logic [2*DW-1:0]   exp_beat;
  logic              start_q;
  logic              start_re;
  logic              start_ok;
  logic              dvalid_q;
  logic              dvalid_fe;
  logic              last_addr;
  logic              all_beats;
  logic              done_q;
  logic              fault_q;
  logic              busy_q;

  // Starts at one so a start held through reset is not an edge
  assign start_re  = harness_control_i[0] && !start_q;
  assign start_ok  = (state == TEST_IDLE) && start_re && ddr.phy_rdy;
  assign dvalid_fe = dvalid_q && !ddr.dvalid;

  assign last_addr = (addr_cnt == BA_W'(`DDR_MEM_WORDS - 1));
  assign all_beats = (data_cnt == DW'(2*`DDR_MEM_WORDS));

  // Beat k is the counter repeated in both halves
  assign exp_beat = {data_cnt, data_cnt};

  // Command and data strobes, held off by almost-full
  always_comb begin
    ddr.af_we = 1'b0;
    ddr.df_we = 1'b0;
    case (state)
      WR_BEAT_0: begin
        // Command and first beat go in together or not at all
        ddr.af_we = !ddr.af_afull && !ddr.df_afull;
        ddr.df_we = !ddr.af_afull && !ddr.df_afull;
      end
      WR_BEAT_1: ddr.df_we = !ddr.df_afull;
      RD_ISSUE:  ddr.af_we = !ddr.af_afull;
      default: ;
    endcase
  end

  assign ddr.cmd   = (state == RD_ISSUE) ? CMD_READ : CMD_WRITE;
  assign ddr.addr  = AW'({addr_cnt, 2'b00});
  assign ddr.wdata = exp_beat;
  assign ddr.mask  = {MASK_W{1'b1}};  // Full-word writes only

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= TEST_IDLE;
      addr_cnt <= '0;
      data_cnt <= '0;
      start_q  <= 1'b1;
      dvalid_q <= 1'b0;
      done_q   <= 1'b0;
      fault_q  <= 1'b0;
      busy_q   <= 1'b0;
    end else begin
      start_q  <= harness_control_i[0];
      dvalid_q <= ddr.dvalid;

      // Pattern advances on every write beat and every returned beat
      if (ddr.df_we || ddr.dvalid) begin
        data_cnt <= data_cnt + 1'b1;
      end

      // Read comparator, sticky until the next accepted start
      if (ddr.dvalid && (ddr.rdata != exp_beat)) begin
        fault_q <= 1'b1;
      end

      case (state)
        TEST_IDLE: begin
          if (start_ok) begin
            state    <= WR_BEAT_0;
            addr_cnt <= '0;
            data_cnt <= '0;
            busy_q   <= 1'b1;
            done_q   <= 1'b0;
            fault_q  <= 1'b0;
          end
        end
        WR_BEAT_0: begin
          if (ddr.af_we) state <= WR_BEAT_1;  // Else stalled
        end
        WR_BEAT_1: begin
          if (ddr.df_we) begin
            addr_cnt <= addr_cnt + 1'b1;
            state    <= last_addr ? TEST_WAIT : WR_BEAT_0;
          end
        end
        TEST_WAIT: begin
          // Read pass replays the pattern from zero
          addr_cnt <= '0;
          data_cnt <= '0;
          state    <= RD_ISSUE;
        end
        RD_ISSUE: begin
          if (ddr.af_we) begin
            addr_cnt <= addr_cnt + 1'b1;
            if (last_addr) state <= WAIT_FOR_DATA;
          end
        end
        WAIT_FOR_DATA: begin
          // Several bursts may still be queued, so count the beats too
          if (dvalid_fe && all_beats) begin
            state  <= TEST_IDLE;
            done_q <= 1'b1;
            busy_q <= 1'b0;
          end
        end
        default: state <= TEST_IDLE;
      endcase
    end
  end

  always_comb begin
    harness_status_o         = '0;
    harness_status_o.done    = done_q;
    harness_status_o.fault   = fault_q;
    harness_status_o.phy_rdy = ddr.phy_rdy;
    harness_status_o.busy    = busy_q;
  end

endmodule

// File: ddr_test_top.sv
// Memory test harness on a behavioral DDR2 controller
module ddr_test_top (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] harness_control_i,  // Bit 0 starts a run
  input  logic        fault_inject_i,     // Stuck-at-one on read bit 0
  output logic [31:0] harness_status_o    // {reserved, busy, phy_rdy, fault, done}
);

  // User-side bus between harness and controller
  ddr_user_if ddr_bus ();

  ddr_test_harness u_harness (
    .clk               (clk),
    .reset             (reset),
    .harness_control_i (harness_control_i),
    .harness_status_o  (harness_status_o),
    .ddr               (ddr_bus.harness)
  );

  ddr_mem_model u_mem_model (
    .clk            (clk),
    .reset          (reset),
    .fault_inject_i (fault_inject_i),
    .ddr            (ddr_bus.ctrl)
  );

endmodule

// File: ddr_user_if.sv
`include "ddr_consts.svh"

// User side of the DDR2 controller
interface ddr_user_if
  import ddr_pkg::*;
();

  ddr_cmd_e                          cmd;      // Taken on af_we
  logic [`DDR_ADDR_WIDTH-1:0]        addr;     // Taken on af_we
  logic [2*`DDR_DATA_WIDTH-1:0]      wdata;    // Taken on df_we
  logic [2*`DDR_DATA_WIDTH/8-1:0]    mask;     // Byte enables, taken on df_we
  logic                              af_we;
  logic                              df_we;
  logic                              af_afull;
  logic                              df_afull;
  logic [2*`DDR_DATA_WIDTH-1:0]      rdata;    // Valid while dvalid
  logic                              dvalid;
  logic                              phy_rdy;  // Calibration finished

  modport harness (
    output cmd, addr, wdata, mask, af_we, df_we,
    input  af_afull, df_afull, rdata, dvalid, phy_rdy
  );

  modport ctrl (
    input  cmd, addr, wdata, mask, af_we, df_we,
    output af_afull, df_afull, rdata, dvalid, phy_rdy
  );

endinterface

// File: run.sh
#!/bin/sh
# Verilator build and run of the DDR2 test harness bench

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_ddr_test_top

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -f all.f --top-module "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
  echo "Result: pass"
  exit 0
fi
echo "Result: fail"
exit 1

// File: tb_ddr_test_top.sv
`include "ddr_consts.svh"

module tb_ddr_test_top
  import ddr_pkg::*;
();

  localparam int CAL_CYCLES    = `DDR_CAL_CYCLES;
  localparam int RESET_CYCLES  = 16;
  localparam int RANDOM_RUNS   = 12;
  localparam int DIRECTED_RUNS = 3;
  localparam int HOLD_CYCLES   = 20;
  // Worst case per run plus slack for gaps and held starts
  localparam int RUN_BUDGET  = 4*`DDR_MEM_WORDS*(`DDR_RD_LATENCY + 4) + 64;
  localparam int CYCLE_LIMIT = (RANDOM_RUNS + DIRECTED_RUNS)*RUN_BUDGET
                               + CAL_CYCLES + RESET_CYCLES + 64;

  logic            clk;
  logic            reset;
  logic [31:0]     harness_control;
  logic            fault_inject;
  harness_status_t status;
  harness_status_t exp_status;   // Reference model of the status word
  logic [31:0]     lfsr;
  int              cycle_count = 0;

  ddr_test_top DUT (
    .clk               (clk),
    .reset             (reset),
    .harness_control_i (harness_control),
    .fault_inject_i    (fault_inject),
    .harness_status_o  (status)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Guards against a run that never finishes
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      stop_with_error($sformatf("timeout: no result after %0d cycles", cycle_count));
    end
  end

  task automatic check_status(input harness_status_t got, input harness_status_t exp,
                              input string where);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch at %0t: harness_status_o (%s) got %h expected %h",
                                $time, where, got, exp));
    end
  endtask

  task automatic check_phy_rdy(input bit got, input bit exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch at %0t: phy_rdy got %0b expected %0b",
                                $time, got, exp));
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic        fb;
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic harness_status_t make_status(input bit done, input bit fault,
                                                  input bit phy_rdy, input bit busy);
    harness_status_t s;
    s         = '0;
    s.done    = done;
    s.fault   = fault;
    s.phy_rdy = phy_rdy;
    s.busy    = busy;
    return s;
  endfunction

  // n counts rising edges since reset fell; start pulse here must be ignored
  task automatic check_calibration();
    for (int n = 0; n <= CAL_CYCLES + 4; n++) begin
      if (n == 10) harness_control[0] = 1'b1;
      if (n == 14) harness_control[0] = 1'b0;
      check_phy_rdy(status.phy_rdy, n >= CAL_CYCLES);
      check_status(status, make_status(0, 0, n >= CAL_CYCLES, 0), "calibration");
      @(negedge clk);
    end
  endtask

  task automatic do_run(input bit fault_en, input int gap, input int pulse_len,
                        input bit hold_after, input bit poke_busy);
    int cnt;
    for (int i = 0; i < gap; i++) begin
      check_status(status, exp_status, "idle gap");  // Last result holds
      @(negedge clk);
    end
    fault_inject       = fault_en;
    harness_control[0] = 1'b1;
    @(negedge clk);
    exp_status = make_status(0, 0, 1, 1);
    check_status(status, exp_status, "run start");
    cnt = 1;
    while (status.busy) begin
      if (status.done) stop_with_error("done flag set while the run was still busy");
      if (!hold_after && cnt == pulse_len) harness_control[0] = 1'b0;
      // Second edge while busy has no effect
      if (poke_busy && cnt == pulse_len + 4) harness_control[0] = 1'b1;
      if (poke_busy && cnt == pulse_len + 8) harness_control[0] = 1'b0;
      @(negedge clk);
      cnt++;
    end
    exp_status = make_status(1, fault_en, 1, 0);
    check_status(status, exp_status, "run end");
    if (hold_after) begin
      for (int i = 0; i < HOLD_CYCLES; i++) begin
        @(negedge clk);
        check_status(status, exp_status, "start held");
      end
      harness_control[0] = 1'b0;
    end
  endtask

  initial begin
    logic [31:0] gap;
    logic [31:0] plen;
    logic [31:0] fe;
    logic [31:0] hold;
    logic [31:0] poke;
    harness_control = '0;
    fault_inject    = 1'b0;
    reset           = 1'b1;
    lfsr            = 32'h063325cf;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    check_status(status, '0, "reset");
    reset = 1'b0;
    check_calibration();
    exp_status = make_status(0, 0, 1, 0);

    do_run(1'b0, 3, 2, 1'b0, 1'b0);  // Clean pass
    do_run(1'b1, 3, 1, 1'b0, 1'b1);  // Stuck bit plus a start edge while busy
    do_run(1'b1, 2, 1, 1'b1, 1'b0);  // Start held past the end

    for (int r = 0; r < RANDOM_RUNS; r++) begin
      gap  = take_bits(4);
      plen = take_bits(3);
      fe   = take_bits(1);
      hold = take_bits(1);
      poke = take_bits(1);
      do_run(fe[0], int'(gap) + 1, int'(plen) + 1, hold[0], poke[0] && !hold[0]);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
